// ==== aline_acq.f ====
+incdir+src
src/aline_pkg.sv
src/acq_ctrl_if.sv
src/aline_buffer.sv
src/aline_sequencer.sv
src/aline_csr.sv
src/aline_acq_top.sv
tests/aline_acq_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the a-line acquisition testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log
build_dir=obj_dir

verilator --binary --timing --top-module aline_acq_tb -f aline_acq.f \
	--Mdir "$build_dir" -o aline_acq_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/aline_acq_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# verdict from the log
if grep -q "STATUS: FAIL" "$log_file"; then
	exit 1
fi
exit 0

// ==== src/acq_ctrl_if.sv ====
`timescale 1ns/1ps
`include "aline_settings.svh"

interface acq_ctrl_if;

	// ==============================
	// configuration from registers
	// ==============================

	// samples per line
	logic [`ALINE_ADDR_W-1:0] nsamples;
	// one-cycle arm request
	logic arm;
	// readback format select
	logic offset_binary;

	// ==============================
	// status from sequencer
	// ==============================
	logic busy;
	logic done;
	// samples written so far
	logic [`ALINE_ADDR_W-1:0] count;

	// register block side
	modport csr_mp (
		output nsamples,
		output arm,
		output offset_binary,
		input  busy,
		input  done,
		input  count
	);

	// sequencer side
	modport seq_mp (
		input  nsamples,
		input  arm,
		input  offset_binary,
		output busy,
		output done,
		output count
	);

endinterface

// ==== src/aline_acq_top.sv ====
`timescale 1ns/1ps
`include "aline_settings.svh"

module aline_acq_top (
	input  logic                       clk_system,
	input  logic                       global_reset_n,
	// axi4-lite slave
	input  logic [`AXI_ADDR_W-1:0]     awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [`AXI_DATA_W-1:0]     wdata,
	input  logic [`AXI_DATA_W/8-1:0]   wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	output aline_pkg::axi_resp_t       bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  logic [`AXI_ADDR_W-1:0]     araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [`AXI_DATA_W-1:0]     rdata,
	output aline_pkg::axi_resp_t       rresp,
	output logic                       rvalid,
	input  logic                       rready,
	// sweep source and adc
	input  logic                       trigger,
	input  logic [`ALINE_SAMPLE_W-1:0] adc_data,
	output logic                       acq_busy,
	output logic [`ALINE_ADDR_W-1:0]   sample_pos
);

	logic                       wr_en;
	logic [`ALINE_ADDR_W-1:0]   wr_addr;
	logic [`ALINE_SAMPLE_W-1:0] wr_data;
	logic [`ALINE_ADDR_W-1:0]   rd_addr;
	logic [`ALINE_SAMPLE_W-1:0] rd_data;

	// register block to sequencer
	acq_ctrl_if ctrl_bus ();

	assign acq_busy = ctrl_bus.busy;

	// ==============================
	// decode
	// ==============================
	aline_csr u_csr (
		.clk_system     (clk_system),
		.global_reset_n (global_reset_n),
		.awaddr         (awaddr),
		.awvalid        (awvalid),
		.awready        (awready),
		.wdata          (wdata),
		.wstrb          (wstrb),
		.wvalid         (wvalid),
		.wready         (wready),
		.bresp          (bresp),
		.bvalid         (bvalid),
		.bready         (bready),
		.araddr         (araddr),
		.arvalid        (arvalid),
		.arready        (arready),
		.rdata          (rdata),
		.rresp          (rresp),
		.rvalid         (rvalid),
		.rready         (rready),
		.ctrl           (ctrl_bus.csr_mp),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data)
	);

	// ==============================
	// execute
	// ==============================
	aline_sequencer u_sequencer (
		.clk_system     (clk_system),
		.global_reset_n (global_reset_n),
		.trigger        (trigger),
		.adc_data       (adc_data),
		.ctrl           (ctrl_bus.seq_mp),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.sample_pos     (sample_pos)
	);

	// ==============================
	// result
	// ==============================
	aline_buffer u_buffer (
		.clk_system (clk_system),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data)
	);

endmodule

// ==== src/aline_buffer.sv ====
`timescale 1ns/1ps
`include "aline_settings.svh"

module aline_buffer (
	input  logic                       clk_system,
	// write port from the sequencer
	input  logic                       wr_en,
	input  logic [`ALINE_ADDR_W-1:0]   wr_addr,
	input  logic [`ALINE_SAMPLE_W-1:0] wr_data,
	// read port towards the register block
	input  logic [`ALINE_ADDR_W-1:0]   rd_addr,
	output logic [`ALINE_SAMPLE_W-1:0] rd_data
);

	// ==============================
	// line storage
	// ==============================

	// one a-line, 2048 samples deep
	logic [`ALINE_SAMPLE_W-1:0] mem [0:(1 << `ALINE_ADDR_W)-1];

	always_ff @(posedge clk_system) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read, one cycle latency
	always_ff @(posedge clk_system) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== src/aline_csr.sv ====
`timescale 1ns/1ps
`include "aline_settings.svh"

module aline_csr (
	input  logic                      clk_system,
	input  logic                      global_reset_n,
	// write address and data
	input  logic [`AXI_ADDR_W-1:0]    awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [`AXI_DATA_W-1:0]    wdata,
	input  logic [`AXI_DATA_W/8-1:0]  wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output aline_pkg::axi_resp_t      bresp,
	output logic                      bvalid,
	input  logic                      bready,
	// read address and data
	input  logic [`AXI_ADDR_W-1:0]    araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output logic [`AXI_DATA_W-1:0]    rdata,
	output aline_pkg::axi_resp_t      rresp,
	output logic                      rvalid,
	input  logic                      rready,
	// control and status towards sequencer
	acq_ctrl_if.csr_mp                ctrl,
	// line buffer read port
	output logic [`ALINE_ADDR_W-1:0]  rd_addr,
	input  logic [`ALINE_SAMPLE_W-1:0] rd_data
);

	logic                     w_accept;
	logic                     r_accept;
	// read accepted last cycle, buffer word on its way
	logic                     rd_wait;
	aline_pkg::reg_addr_t     rd_sel;
	logic [`ALINE_ADDR_W-1:0] rd_ptr;
	logic [`ALINE_SAMPLE_W-1:0] rd_word;

	// ==============================
	// handshakes
	// ==============================

	// both channels taken together, only with no response held
	assign w_accept = awvalid && wvalid && !bvalid;
	assign awready  = w_accept;
	assign wready   = w_accept;

	// one read in flight at a time
	assign r_accept = arvalid && !rd_wait && !rvalid;
	assign arready  = r_accept;

	assign rd_addr  = rd_ptr;

	// sign bit flip for offset binary
	assign rd_word  = rd_data ^ {ctrl.offset_binary, {(`ALINE_SAMPLE_W-1){1'b0}}};

	// ==============================
	// write side and configuration
	// ==============================
	always_ff @(posedge clk_system) begin
		if (!global_reset_n) begin
			bvalid             <= 1'b0;
			ctrl.arm           <= 1'b0;
			ctrl.offset_binary <= 1'b0;
			ctrl.nsamples      <= `ALINE_ADDR_W'(`ALINE_DEFAULT_NSAMPLES);
			rd_ptr             <= '0;
		end else begin
			// arm lasts one cycle
			ctrl.arm <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			// pointer steps after each RDDATA word goes out
			if (rd_wait && rd_sel == aline_pkg::RDDATA)
				rd_ptr <= rd_ptr + 1'b1;
			if (w_accept) begin
				bvalid <= 1'b1;
				bresp  <= aline_pkg::OKAY;
				case (aline_pkg::reg_addr_t'(awaddr))
					aline_pkg::CTRL: begin
						if (wstrb[0]) begin
							ctrl.arm           <= wdata[0];
							ctrl.offset_binary <= wdata[1];
						end
					end
					aline_pkg::NSAMPLES: begin
						if (wstrb[0])
							ctrl.nsamples[7:0] <= wdata[7:0];
						if (wstrb[1])
							ctrl.nsamples[`ALINE_ADDR_W-1:8] <= wdata[`ALINE_ADDR_W-1:8];
					end
					aline_pkg::RDPTR: begin
						// host write wins over a readback step
						if (wstrb[0])
							rd_ptr[7:0] <= wdata[7:0];
						if (wstrb[1])
							rd_ptr[`ALINE_ADDR_W-1:8] <= wdata[`ALINE_ADDR_W-1:8];
					end
					// STATUS and RDDATA are read only
					default: bresp <= aline_pkg::SLVERR;
				endcase
			end
		end
	end

	// ==============================
	// read side
	// ==============================
	always_ff @(posedge clk_system) begin
		if (!global_reset_n) begin
			rd_wait <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			rd_wait <= r_accept;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_wait)
				rvalid <= 1'b1;
		end
	end

	// address latch and read mux, payload only
	always_ff @(posedge clk_system) begin
		if (r_accept)
			rd_sel <= aline_pkg::reg_addr_t'(araddr);
		if (rd_wait) begin
			rresp <= aline_pkg::OKAY;
			case (rd_sel)
				aline_pkg::CTRL:     rdata <= `AXI_DATA_W'({ctrl.offset_binary, 1'b0});
				aline_pkg::NSAMPLES: rdata <= `AXI_DATA_W'(ctrl.nsamples);
				// count in 26:16, done and busy at the bottom
				aline_pkg::STATUS:   rdata <= `AXI_DATA_W'({ctrl.count, 14'd0, ctrl.done, ctrl.busy});
				aline_pkg::RDPTR:    rdata <= `AXI_DATA_W'(rd_ptr);
				aline_pkg::RDDATA:   rdata <= `AXI_DATA_W'(rd_word);
				default: begin
					rdata <= '0;
					rresp <= aline_pkg::SLVERR;
				end
			endcase
		end
	end

endmodule

// ==== src/aline_pkg.sv ====
`include "aline_settings.svh"

package aline_pkg;

	// ==============================
	// sequencer states
	// ==============================
	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		ARMED   = 2'd1,
		CAPTURE = 2'd2,
		DONE    = 2'd3
	} acq_state_t;

	// ==============================
	// register map, byte addresses
	// ==============================
	typedef enum logic [`AXI_ADDR_W-1:0] {
		CTRL     = `AXI_ADDR_W'h00,
		NSAMPLES = `AXI_ADDR_W'h04,
		STATUS   = `AXI_ADDR_W'h08,
		RDPTR    = `AXI_ADDR_W'h0C,
		RDDATA   = `AXI_ADDR_W'h10
	} reg_addr_t;

	// axi response codes in use
	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		SLVERR = 2'd2
	} axi_resp_t;

endpackage

// ==== src/aline_sequencer.sv ====
`timescale 1ns/1ps
`include "aline_settings.svh"

module aline_sequencer (
	input  logic                       clk_system,
	input  logic                       global_reset_n,
	// sweep trigger and adc samples, already on clk_system
	input  logic                       trigger,
	input  logic [`ALINE_SAMPLE_W-1:0] adc_data,
	acq_ctrl_if.seq_mp                 ctrl,
	// line buffer write port
	output logic                       wr_en,
	output logic [`ALINE_ADDR_W-1:0]   wr_addr,
	output logic [`ALINE_SAMPLE_W-1:0] wr_data,
	output logic [`ALINE_ADDR_W-1:0]   sample_pos
);

	aline_pkg::acq_state_t      state;
	logic                       trig_q;
	logic                       trig_d;
	logic                       trig_rise;
	logic [`ALINE_SAMPLE_W-1:0] adc_q;
	// next buffer address to fill
	logic [`ALINE_ADDR_W-1:0]   pos;

	assign trig_rise  = trig_q && !trig_d;
	assign sample_pos = pos;

	// status straight from the state
	assign ctrl.busy  = (state == aline_pkg::ARMED) || (state == aline_pkg::CAPTURE);
	assign ctrl.done  = (state == aline_pkg::DONE);

	// ==============================
	// sample path
	// ==============================

	// input register, then write register
	// pos is zero while armed so the first write lands at 0
	always_ff @(posedge clk_system) begin
		adc_q   <= adc_data;
		wr_data <= adc_q;
		wr_addr <= pos;
	end

	// ==============================
	// capture FSM
	// ==============================
	always_ff @(posedge clk_system) begin
		if (!global_reset_n) begin
			state      <= aline_pkg::IDLE;
			trig_q     <= 1'b0;
			trig_d     <= 1'b0;
			wr_en      <= 1'b0;
			pos        <= '0;
			ctrl.count <= '0;
		end else begin
			trig_q <= trigger;
			trig_d <= trig_q;
			wr_en  <= 1'b0;
			// count follows the writes that reach the buffer
			if (wr_en)
				ctrl.count <= ctrl.count + 1'b1;
			case (state)
				aline_pkg::IDLE,
				aline_pkg::DONE: begin
					if (ctrl.arm) begin
						ctrl.count <= '0;
						pos        <= '0;
						// empty line finishes at once
						state <= (ctrl.nsamples == '0) ? aline_pkg::DONE : aline_pkg::ARMED;
					end
				end
				aline_pkg::ARMED: begin
					if (trig_rise) begin
						// sample 0 already sits in adc_q
						state <= aline_pkg::CAPTURE;
						wr_en <= 1'b1;
						pos   <= pos + 1'b1;
					end
				end
				aline_pkg::CAPTURE: begin
					if (pos >= ctrl.nsamples) begin
						// last write goes in on this edge
						state <= aline_pkg::DONE;
					end else begin
						wr_en <= 1'b1;
						pos   <= pos + 1'b1;
					end
				end
				default: state <= aline_pkg::IDLE;
			endcase
		end
	end

endmodule

// ==== src/aline_settings.svh ====
`ifndef ALINE_SETTINGS_SVH
`define ALINE_SETTINGS_SVH

// ==============================
// acquisition sizes
// ==============================

// adc sample width in bits
`define ALINE_SAMPLE_W 14

// line buffer index and sample counter width, 2048 entries
`define ALINE_ADDR_W 11

// samples per a-line after reset
`define ALINE_DEFAULT_NSAMPLES 1170

// ==============================
// axi4-lite bus
// ==============================
`define AXI_ADDR_W 5
`define AXI_DATA_W 32

`endif

// ==== tests/aline_acq_tb.sv ====
`timescale 1ns/1ps
`include "aline_settings.svh"

module aline_acq_tb;

	localparam int WAIT_LIMIT = 500;

	// conditions the handshake waits can poll
	typedef enum {AWREADY_HIGH, BVALID_HIGH, ARREADY_HIGH, RVALID_HIGH, BUSY_HIGH, BUSY_LOW}
		wait_cond_t;

	logic                       clk_system = 1'b0;
	logic                       global_reset_n;
	logic [`AXI_ADDR_W-1:0]     awaddr;
	logic                       awvalid;
	logic                       awready;
	logic [`AXI_DATA_W-1:0]     wdata;
	logic [`AXI_DATA_W/8-1:0]   wstrb;
	logic                       wvalid;
	logic                       wready;
	aline_pkg::axi_resp_t       bresp;
	logic                       bvalid;
	logic                       bready;
	logic [`AXI_ADDR_W-1:0]     araddr;
	logic                       arvalid;
	logic                       arready;
	logic [`AXI_DATA_W-1:0]     rdata;
	aline_pkg::axi_resp_t       rresp;
	logic                       rvalid;
	logic                       rready;
	logic                       trigger;
	logic [`ALINE_SAMPLE_W-1:0] adc_data = '0;
	logic                       acq_busy;
	logic [`ALINE_ADDR_W-1:0]   sample_pos;

	// adc values seen by the DUT by edge index from the trigger
	logic [`ALINE_SAMPLE_W-1:0] adc_log [0:(1 << `ALINE_ADDR_W)-1];
	// expected buffer contents
	logic [`ALINE_SAMPLE_W-1:0] ref_line [0:(1 << `ALINE_ADDR_W)-1];
	logic [`ALINE_ADDR_W:0]     log_idx = '0;
	logic                       logging = 1'b0;
	logic                       trig_seen = 1'b0;
	integer                     seed = 32'ha482_fa0b;
	logic                       abort_req = 1'b0;
	int                         checks = 0;
	int                         errors = 0;

	aline_acq_top UUT (
		.clk_system     (clk_system),
		.global_reset_n (global_reset_n),
		.awaddr         (awaddr),
		.awvalid        (awvalid),
		.awready        (awready),
		.wdata          (wdata),
		.wstrb          (wstrb),
		.wvalid         (wvalid),
		.wready         (wready),
		.bresp          (bresp),
		.bvalid         (bvalid),
		.bready         (bready),
		.araddr         (araddr),
		.arvalid        (arvalid),
		.arready        (arready),
		.rdata          (rdata),
		.rresp          (rresp),
		.rvalid         (rvalid),
		.rready         (rready),
		.trigger        (trigger),
		.adc_data       (adc_data),
		.acq_busy       (acq_busy),
		.sample_pos     (sample_pos)
	);

	// 4 ns period
	always #2 clk_system = ~clk_system;

	// ==============================
	// adc source and sample log
	// ==============================
	always @(posedge clk_system) begin
		// trigger first sampled high restarts the log
		if (trigger && !trig_seen) begin
			log_idx = '0;
			logging = 1'b1;
		end
		if (logging && !log_idx[`ALINE_ADDR_W]) begin
			adc_log[log_idx[`ALINE_ADDR_W-1:0]] = adc_data;
			log_idx = log_idx + 1'b1;
		end
		trig_seen = trigger;
		adc_data <= `ALINE_SAMPLE_W'($random(seed));
	end

	// ends the run after a wait gave up
	initial begin
		wait (abort_req);
		$display("checks %0d, errors %0d, run aborted", checks, errors);
		$display("STATUS: FAIL");
		$finish;
	end

	// expected RDDATA word for one logged sample
	function automatic logic [31:0] expected_sample(input logic [`ALINE_SAMPLE_W-1:0] raw,
			input logic offset_bin);
		logic [`ALINE_SAMPLE_W-1:0] word;
		word = raw;
		// offset binary is two's complement with the sign bit flipped
		if (offset_bin)
			word[`ALINE_SAMPLE_W-1] = ~word[`ALINE_SAMPLE_W-1];
		return 32'(word);
	endfunction

	function automatic logic cond_met(input wait_cond_t c);
		case (c)
			AWREADY_HIGH: return awready && wready;
			BVALID_HIGH:  return bvalid;
			ARREADY_HIGH: return arready;
			RVALID_HIGH:  return rvalid;
			BUSY_HIGH:    return acq_busy;
			default:      return !acq_busy;
		endcase
	endfunction

	// returns on the rising edge where the condition holds
	task automatic wait_until(input wait_cond_t c);
		int n;
		n = 0;
		@(posedge clk_system);
		while (!cond_met(c) && n < WAIT_LIMIT) begin
			@(posedge clk_system);
			n++;
		end
		if (!cond_met(c)) begin
			$display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, c.name());
			abort_req = 1'b1;
			forever @(posedge clk_system);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
		end
	endtask

	task automatic check_resp(input string name, input aline_pkg::axi_resp_t expected,
			input aline_pkg::axi_resp_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %s: expected %s, actual %s", name, expected.name(), actual.name());
		end
	endtask

	// ==============================
	// axi4-lite master
	// ==============================

	// with bready low this returns as soon as bvalid shows
	task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data,
			output aline_pkg::axi_resp_t resp);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		wait_until(AWREADY_HIGH);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		wait_until(BVALID_HIGH);
		resp = bresp;
	endtask

	task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr, output logic [31:0] data,
			output aline_pkg::axi_resp_t resp);
		araddr  <= addr;
		arvalid <= 1'b1;
		wait_until(ARREADY_HIGH);
		arvalid <= 1'b0;
		wait_until(RVALID_HIGH);
		data = rdata;
		resp = rresp;
	endtask

	// ==============================
	// capture helpers
	// ==============================
	task automatic pulse_trigger();
		trigger <= 1'b1;
		@(posedge clk_system);
		trigger <= 1'b0;
		@(posedge clk_system);
	endtask

	task automatic capture_line(input string name, input logic [31:0] n);
		aline_pkg::axi_resp_t resp;
		logic [31:0] data;
		axi_write(aline_pkg::NSAMPLES, n, resp);
		check_resp({name, "_nsamples"}, aline_pkg::OKAY, resp);
		axi_write(aline_pkg::CTRL, 32'h1, resp);
		check_resp({name, "_arm"}, aline_pkg::OKAY, resp);
		wait_until(BUSY_HIGH);
		// arm puts the line position back to the start
		check_word({name, "_armed_pos"}, 32'h0, 32'(sample_pos));
		// armed means busy with done cleared and count back to 0
		axi_read(aline_pkg::STATUS, data, resp);
		check_word({name, "_armed"}, 32'h1, data);
		pulse_trigger();
		wait_until(BUSY_LOW);
		// position stops at the line length
		check_word({name, "_end_pos"}, n, 32'(sample_pos));
		axi_read(aline_pkg::STATUS, data, resp);
		check_word({name, "_status"}, {5'd0, n[`ALINE_ADDR_W-1:0], 14'd0, 2'b10}, data);
	endtask

	// copy the first n logged samples into the buffer model
	task automatic keep_samples(input int n);
		logic [`ALINE_ADDR_W-1:0] k;
		for (int i = 0; i < n; i++) begin
			k = `ALINE_ADDR_W'(i);
			ref_line[k] = adc_log[k];
		end
	endtask

	task automatic check_line(input string name, input int n, input logic offset_bin);
		aline_pkg::axi_resp_t resp;
		logic [31:0] data;
		logic [`ALINE_ADDR_W-1:0] k;
		axi_write(aline_pkg::RDPTR, 32'd0, resp);
		check_resp({name, "_rdptr"}, aline_pkg::OKAY, resp);
		for (int i = 0; i < n; i++) begin
			k = `ALINE_ADDR_W'(i);
			axi_read(aline_pkg::RDDATA, data, resp);
			check_resp($sformatf("%s_resp_%0d", name, i), aline_pkg::OKAY, resp);
			check_word($sformatf("%s_word_%0d", name, i), expected_sample(ref_line[k], offset_bin),
				data);
		end
	endtask

	// ==============================
	// test sequence
	// ==============================
	initial begin
		aline_pkg::axi_resp_t resp;
		logic [31:0] data;
		global_reset_n = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = 4'hf;
		wvalid  = 1'b0;
		bready  = 1'b1;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b1;
		trigger = 1'b0;
		repeat (2) @(posedge clk_system);
		global_reset_n <= 1'b1;

		// reset values
		axi_read(aline_pkg::STATUS, data, resp);
		check_word("reset_status", 32'h0, data);
		axi_read(aline_pkg::NSAMPLES, data, resp);
		check_word("reset_nsamples", 32'd1170, data);
		check_word("reset_busy", 32'h0, 32'(acq_busy));

		// trigger while idle does nothing
		pulse_trigger();
		axi_read(aline_pkg::STATUS, data, resp);
		check_word("idle_trigger_status", 32'h0, data);

		// register access and error responses
		axi_write(aline_pkg::NSAMPLES, 32'd16, resp);
		check_resp("nsamples_write", aline_pkg::OKAY, resp);
		axi_read(aline_pkg::NSAMPLES, data, resp);
		check_resp("nsamples_read_resp", aline_pkg::OKAY, resp);
		check_word("nsamples_read", 32'd16, data);
		axi_write(aline_pkg::STATUS, 32'h3, resp);
		check_resp("status_write", aline_pkg::SLVERR, resp);
		axi_write(aline_pkg::RDDATA, 32'h3, resp);
		check_resp("rddata_write", aline_pkg::SLVERR, resp);
		axi_write(5'h14, 32'h3, resp);
		check_resp("unmapped_write", aline_pkg::SLVERR, resp);
		axi_read(5'h14, data, resp);
		check_resp("unmapped_read_resp", aline_pkg::SLVERR, resp);
		check_word("unmapped_read", 32'h0, data);

		// capture with two's complement readback
		capture_line("cap16", 32'd16);
		keep_samples(16);
		check_line("twos", 16, 1'b0);

		// same line in offset binary
		axi_write(aline_pkg::CTRL, 32'h2, resp);
		check_resp("format_write", aline_pkg::OKAY, resp);
		check_line("offset", 16, 1'b1);

		// trigger in done then a shorter line over the old one
		pulse_trigger();
		axi_read(aline_pkg::STATUS, data, resp);
		check_word("done_trigger_status", 32'h0010_0002, data);
		capture_line("cap8", 32'd8);
		keep_samples(8);
		check_line("recapture", 16, 1'b0);

		// write response held while bready is low
		bready <= 1'b0;
		axi_write(aline_pkg::NSAMPLES, 32'd20, resp);
		awaddr  <= aline_pkg::RDPTR;
		wdata   <= 32'd5;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		repeat (4) begin
			@(posedge clk_system);
			check_word("bp_bvalid", 32'h1, 32'(bvalid));
			check_resp("bp_bresp", aline_pkg::OKAY, bresp);
			check_word("bp_awready", 32'h0, 32'(awready));
		end
		bready <= 1'b1;
		wait_until(AWREADY_HIGH);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		wait_until(BVALID_HIGH);
		check_resp("bp_second_write", aline_pkg::OKAY, bresp);

		// read response held while rready is low
		rready <= 1'b0;
		axi_read(aline_pkg::NSAMPLES, data, resp);
		araddr  <= aline_pkg::RDPTR;
		arvalid <= 1'b1;
		repeat (4) begin
			@(posedge clk_system);
			check_word("bp_rvalid", 32'h1, 32'(rvalid));
			check_word("bp_rdata", 32'd20, rdata);
			check_word("bp_arready", 32'h0, 32'(arready));
		end
		rready <= 1'b1;
		wait_until(ARREADY_HIGH);
		arvalid <= 1'b0;
		wait_until(RVALID_HIGH);
		check_resp("bp_second_resp", aline_pkg::OKAY, rresp);
		check_word("bp_second_read", 32'd5, rdata);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
